// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    // ------------------------------------------------------------------
    // Major opcodes as encoded in instruction bits 6 to 0
    // ------------------------------------------------------------------
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_OP_IMM = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_IMM_32 = 7'b0011011,
        OP_OP_32  = 7'b0111011,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    // ALU operations picked by the decoder
    // Set-compare ops give 0 or 1, branches map onto them
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_SEQ, ALU_SNE,
        ALU_SGE, ALU_SGEU
    } alu_op_t;

    // Jump conditions
    // JUMP_ON_ALU takes the jump when the ALU result is one
    typedef enum logic [1:0] {
        JUMP_NEVER,
        JUMP_ALWAYS,
        JUMP_ON_ALU
    } jump_cond_t;

endpackage

// File: rtl/ex_stage_pkg.sv
package ex_stage_pkg;

    // ------------------------------------------------------------------
    // Datapath widths
    // ------------------------------------------------------------------
    // Default register width of the core
    localparam int XLEN_DEFAULT = 64;
    // Width of W-suffixed operations
    localparam int WORD_W = 32;
    // Instruction word
    localparam int INSTR_W = 32;

    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [WORD_W-1:0]  word_t;

    // ------------------------------------------------------------------
    // Sequencer states
    // ------------------------------------------------------------------
    typedef enum logic {
        // Waiting for execute_enable
        EX_IDLE,
        // ALU result registered on the way out
        EX_COMPUTE
    } ex_state_t;

endpackage

// File: rtl/ex_operand_if.sv
interface ex_operand_if
    import rv_isa_pkg::*, ex_stage_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
);
    // Operands as the ALU sees them
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    alu_op_t         alu_op;
    // Low-word operation with sign extension
    logic            word_op;

    // Held from one capture to the next
    modport source (output operand_a, operand_b, alu_op, word_op);
    modport sink (input operand_a, operand_b, alu_op, word_op);

endinterface

// File: rtl/ex_operand_select.sv
module ex_operand_select
    import rv_isa_pkg::*, ex_stage_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            capture,
    input  logic            bubble,
    input  opcode_t         op_code,
    input  alu_op_t         alu_op,
    input  logic            word_op,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] reg_a,
    input  logic [XLEN-1:0] reg_b,
    input  logic [XLEN-1:0] immed,
    ex_operand_if.source    ops
);
    logic [XLEN-1:0] sel_a;
    logic [XLEN-1:0] sel_b;
    alu_op_t         sel_op;
    logic            sel_word;

    // ------------------------------------------------------------------
    // Operand choice by major opcode
    // ------------------------------------------------------------------
    always_comb begin
        sel_op   = alu_op;
        sel_word = word_op;
        case (op_code)
            OP_AUIPC: begin
                sel_a = pc;
                sel_b = immed;
            end
            OP_LUI: begin
                sel_a = '0;
                sel_b = immed;
            end
            // Link address pc + 4
            OP_JAL, OP_JALR: begin
                sel_a = pc;
                sel_b = XLEN'(4);
            end
            OP_BRANCH, OP_OP, OP_OP_32: begin
                sel_a = reg_a;
                sel_b = reg_b;
            end
            // OP_IMM, IMM_32, LOAD, STORE and SYSTEM
            default: begin
                sel_a = reg_a;
                sel_b = immed;
            end
        endcase
        // Bubble becomes 0 + 0
        if (bubble) begin
            sel_a    = '0;
            sel_b    = '0;
            sel_op   = ALU_ADD;
            sel_word = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ops.operand_a <= '0;
            ops.operand_b <= '0;
            ops.alu_op    <= ALU_ADD;
            ops.word_op   <= 1'b0;
        end else if (capture) begin
            ops.operand_a <= sel_a;
            ops.operand_b <= sel_b;
            ops.alu_op    <= sel_op;
            ops.word_op   <= sel_word;
        end
    end

    // Decoder must hand over a defined ALU operation
    assert property (@(posedge clk) disable iff (reset)
        capture |=> ops.alu_op inside {[ALU_ADD:ALU_SGEU]});

endmodule

// File: rtl/ex_alu.sv
module ex_alu
    import rv_isa_pkg::*, ex_stage_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            compute,
    ex_operand_if.sink      ops,
    output logic [XLEN-1:0] result
);
    localparam int SHAMT_W  = $clog2(XLEN);
    localparam int WSHAMT_W = $clog2(WORD_W);

    logic [SHAMT_W-1:0]  shamt;
    logic [WSHAMT_W-1:0] wshamt;
    word_t               a_lo;
    word_t               b_lo;
    word_t               word_res;
    logic [XLEN-1:0]     full_res;
    logic [XLEN-1:0]     result_next;
    logic                lt_s;
    logic                lt_u;

    // Shift amounts come from the low bits of operand b only
    assign shamt  = ops.operand_b[SHAMT_W-1:0];
    assign wshamt = ops.operand_b[WSHAMT_W-1:0];
    assign a_lo   = ops.operand_a[WORD_W-1:0];
    assign b_lo   = ops.operand_b[WORD_W-1:0];

    // Shared less-than for SLT/SGE and their unsigned forms
    assign lt_s = $signed(ops.operand_a) < $signed(ops.operand_b);
    assign lt_u = ops.operand_a < ops.operand_b;

    // ------------------------------------------------------------------
    // Full-width operations
    // ------------------------------------------------------------------
    always_comb begin
        case (ops.alu_op)
            ALU_ADD:  full_res = ops.operand_a + ops.operand_b;
            ALU_SUB:  full_res = ops.operand_a - ops.operand_b;
            ALU_AND:  full_res = ops.operand_a & ops.operand_b;
            ALU_OR:   full_res = ops.operand_a | ops.operand_b;
            ALU_XOR:  full_res = ops.operand_a ^ ops.operand_b;
            ALU_SLL:  full_res = ops.operand_a << shamt;
            ALU_SRL:  full_res = ops.operand_a >> shamt;
            ALU_SRA:  full_res = $signed(ops.operand_a) >>> shamt;
            ALU_SLT:  full_res = XLEN'(lt_s);
            ALU_SLTU: full_res = XLEN'(lt_u);
            ALU_SEQ:  full_res = XLEN'(ops.operand_a == ops.operand_b);
            ALU_SNE:  full_res = XLEN'(ops.operand_a != ops.operand_b);
            ALU_SGE:  full_res = XLEN'(!lt_s);
            ALU_SGEU: full_res = XLEN'(!lt_u);
            default:  full_res = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // Word-mode operations on the low 32 bits
    // ------------------------------------------------------------------
    always_comb begin
        case (ops.alu_op)
            ALU_ADD: word_res = a_lo + b_lo;
            ALU_SUB: word_res = a_lo - b_lo;
            ALU_SLL: word_res = a_lo << wshamt;
            ALU_SRL: word_res = a_lo >> wshamt;
            // Arithmetic shift of the signed low word
            ALU_SRA: word_res = $signed(a_lo) >>> wshamt;
            default: word_res = '0;
        endcase
    end

    // Word results are sign-extended from bit 31
    assign result_next = ops.word_op
        ? {{(XLEN-WORD_W){word_res[WORD_W-1]}}, word_res}
        : full_res;

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (compute) begin
            result <= result_next;
        end
    end

    // Decoder sets word mode only for ADDW, SUBW and the W shifts
    assert property (@(posedge clk) disable iff (reset)
        compute && ops.word_op
            |-> ops.alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA});

endmodule

// File: rtl/ex_branch_resolve.sv
module ex_branch_resolve
    import rv_isa_pkg::*, ex_stage_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            capture,
    input  logic            bubble,
    input  jump_cond_t      jump_if,
    input  logic            jump_absolute,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] reg_a,
    input  logic [XLEN-1:0] immed,
    input  logic [XLEN-1:0] alu_result,
    output logic            jump_taken,
    output logic [XLEN-1:0] jump_pc
);
    jump_cond_t      cond_q;
    logic [XLEN-1:0] target_q;
    logic            alu_true;

    // Condition and target held until the next capture
    always_ff @(posedge clk) begin
        if (reset) begin
            cond_q   <= JUMP_NEVER;
            target_q <= '0;
        end else if (capture) begin
            // Bubble never jumps
            cond_q   <= bubble ? JUMP_NEVER : jump_if;
            // JALR is rs1-relative, branches and JAL pc-relative
            target_q <= (jump_absolute ? reg_a : pc) + immed;
        end
    end

    // Branch compares leave exactly one in the ALU result
    assign alu_true = (alu_result == XLEN'(1));

    always_comb begin
        case (cond_q)
            JUMP_ALWAYS: jump_taken = 1'b1;
            JUMP_ON_ALU: jump_taken = alu_true;
            default:     jump_taken = 1'b0;
        endcase
    end

    assign jump_pc = jump_taken ? target_q : '0;

endmodule

// File: rtl/ex_sequencer.sv
module ex_sequencer
    import ex_stage_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   execute_enable,
    input  logic   flush,
    input  instr_t instruction,
    output logic   capture,
    output logic   bubble,
    output logic   compute,
    output logic   execute_done
);
    ex_state_t state;
    ex_state_t state_next;

    // Accept only from idle so one instruction is in flight at most
    assign capture = (state == EX_IDLE) && execute_enable && !flush;
    // All-zero word is a pipeline bubble
    assign bubble  = (instruction == '0);
    assign compute = (state == EX_COMPUTE);

    // ------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            EX_IDLE: begin
                if (capture) begin
                    state_next = EX_COMPUTE;
                end
            end
            // Single compute cycle, flushed or not
            EX_COMPUTE: state_next = EX_IDLE;
            default:    state_next = EX_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= EX_IDLE;
            execute_done <= 1'b0;
        end else begin
            state        <= state_next;
            // Flush in the compute cycle drops the done pulse
            execute_done <= compute && !flush;
        end
    end

    // Done is a single-cycle pulse
    assert property (@(posedge clk) disable iff (reset)
        execute_done |=> !execute_done);

    // No new instruction while one is computing
    assert property (@(posedge clk) disable iff (reset)
        capture |=> compute && !capture);

endmodule

// File: rtl/execute_stage.sv
module execute_stage
    import rv_isa_pkg::*, ex_stage_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            execute_enable,
    input  logic            flush,
    input  instr_t          instruction,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] reg_a,
    input  logic [XLEN-1:0] reg_b,
    input  opcode_t         op_code,
    input  alu_op_t         alu_op,
    input  logic            word_op,
    input  logic [XLEN-1:0] immed,
    input  jump_cond_t      jump_if,
    input  logic            jump_absolute,
    output logic [XLEN-1:0] alu_data_out,
    output logic [XLEN-1:0] jump_pc,
    output logic            jump_taken,
    output logic            execute_done
);
    // Strobes from the sequencer
    logic capture;
    logic bubble;
    logic compute;

    ex_operand_if #(.XLEN(XLEN)) ops_if ();

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------
    ex_sequencer sequencer_i (
        .clk            (clk),
        .reset          (reset),
        .execute_enable (execute_enable),
        .flush          (flush),
        .instruction    (instruction),
        .capture        (capture),
        .bubble         (bubble),
        .compute        (compute),
        .execute_done   (execute_done)
    );

    // ------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------
    ex_operand_select #(.XLEN(XLEN)) operand_select_i (
        .clk     (clk),
        .reset   (reset),
        .capture (capture),
        .bubble  (bubble),
        .op_code (op_code),
        .alu_op  (alu_op),
        .word_op (word_op),
        .pc      (pc),
        .reg_a   (reg_a),
        .reg_b   (reg_b),
        .immed   (immed),
        .ops     (ops_if.source)
    );

    ex_alu #(.XLEN(XLEN)) alu_i (
        .clk     (clk),
        .reset   (reset),
        .compute (compute),
        .ops     (ops_if.sink),
        .result  (alu_data_out)
    );

    // Jump decision reads the registered ALU result
    ex_branch_resolve #(.XLEN(XLEN)) branch_resolve_i (
        .clk           (clk),
        .reset         (reset),
        .capture       (capture),
        .bubble        (bubble),
        .jump_if       (jump_if),
        .jump_absolute (jump_absolute),
        .pc            (pc),
        .reg_a         (reg_a),
        .immed         (immed),
        .alu_result    (alu_data_out),
        .jump_taken    (jump_taken),
        .jump_pc       (jump_pc)
    );

endmodule

// File: sim/execute_model.svh
`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

// ----------------------------------------------------------------------
// Reference model of the execute stage
// ----------------------------------------------------------------------

// Expected ALU output for one operation on two 64-bit operands
function automatic logic [63:0] alu_reference(alu_op_t op, logic word,
                                              logic [63:0] a, logic [63:0] b);
    logic [63:0] flip;
    logic [31:0] w;
    logic [4:0]  sh5;
    logic [5:0]  sh6;
    // Flipping the sign bit turns signed order into unsigned order
    flip = 64'h8000_0000_0000_0000;
    sh5  = b[4:0];
    sh6  = b[5:0];
    if (word) begin
        case (op)
            ALU_ADD: w = a[31:0] + b[31:0];
            ALU_SUB: w = a[31:0] - b[31:0];
            ALU_SLL: w = a[31:0] << sh5;
            ALU_SRL: w = a[31:0] >> sh5;
            // Vacated bits take the sign of the low word
            ALU_SRA: w = (a[31:0] >> sh5) | (a[31] ? ~(32'hffff_ffff >> sh5) : 32'h0);
            default: w = 32'h0;
        endcase
        return {{32{w[31]}}, w};
    end
    case (op)
        ALU_ADD:  return a + b;
        ALU_SUB:  return a - b;
        ALU_AND:  return a & b;
        ALU_OR:   return a | b;
        ALU_XOR:  return a ^ b;
        ALU_SLL:  return a << sh6;
        ALU_SRL:  return a >> sh6;
        ALU_SRA:  return (a >> sh6) | (a[63] ? ~(64'hffff_ffff_ffff_ffff >> sh6) : 64'h0);
        ALU_SLT:  return {63'h0, (a ^ flip) < (b ^ flip)};
        ALU_SLTU: return {63'h0, a < b};
        ALU_SEQ:  return {63'h0, a == b};
        ALU_SNE:  return {63'h0, a != b};
        ALU_SGE:  return {63'h0, (a ^ flip) >= (b ^ flip)};
        ALU_SGEU: return {63'h0, a >= b};
        default:  return 64'h0;
    endcase
endfunction

// Stage result with the operands picked by major opcode
function automatic logic [63:0] stage_result(opcode_t opc, alu_op_t op, logic word,
                                             logic [63:0] pc, logic [63:0] a,
                                             logic [63:0] b, logic [63:0] imm,
                                             logic zero_word);
    if (zero_word) begin
        return 64'h0;
    end
    case (opc)
        OP_LUI:                     return alu_reference(op, word, 64'h0, imm);
        OP_AUIPC:                   return alu_reference(op, word, pc, imm);
        // Link value
        OP_JAL, OP_JALR:            return alu_reference(op, word, pc, 64'd4);
        OP_BRANCH, OP_OP, OP_OP_32: return alu_reference(op, word, a, b);
        default:                    return alu_reference(op, word, a, imm);
    endcase
endfunction

// Taken decision from the condition and the stage result
function automatic logic jump_decision(jump_cond_t cond, logic [63:0] res,
                                       logic zero_word);
    if (zero_word) begin
        return 1'b0;
    end
    case (cond)
        JUMP_ALWAYS: return 1'b1;
        JUMP_ON_ALU: return res == 64'd1;
        default:     return 1'b0;
    endcase
endfunction

// Target address, zero when nothing is taken
function automatic logic [63:0] jump_target(logic taken, logic absolute,
                                            logic [63:0] pc, logic [63:0] a,
                                            logic [63:0] imm);
    if (!taken) begin
        return 64'h0;
    end
    return (absolute ? a : pc) + imm;
endfunction

`endif

// File: sim/execute_stage_tb.sv
module execute_stage_tb
    import rv_isa_pkg::*, ex_stage_pkg::*;
();
    localparam int XLEN       = 64;
    localparam int NUM_TESTS  = 400;
    localparam int SEED       = 29;
    // Cycles allowed from enable to done before giving up
    localparam int DONE_LIMIT = 8;
    // Six cycles per test covers the flush tests, plus reset and margin
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 6 + 100;

    logic            clk;
    logic            reset;
    logic            execute_enable;
    logic            flush;
    instr_t          instruction;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] reg_a;
    logic [XLEN-1:0] reg_b;
    opcode_t         op_code;
    alu_op_t         alu_op;
    logic            word_op;
    logic [XLEN-1:0] immed;
    jump_cond_t      jump_if;
    logic            jump_absolute;
    logic [XLEN-1:0] alu_data_out;
    logic [XLEN-1:0] jump_pc;
    logic            jump_taken;
    logic            execute_done;

    int unsigned value_errors;
    int unsigned protocol_errors;
    string       kind_name;

    `include "execute_model.svh"

    execute_stage #(.XLEN(XLEN)) execute_stage_i (
        .clk            (clk),
        .reset          (reset),
        .execute_enable (execute_enable),
        .flush          (flush),
        .instruction    (instruction),
        .pc             (pc),
        .reg_a          (reg_a),
        .reg_b          (reg_b),
        .op_code        (op_code),
        .alu_op         (alu_op),
        .word_op        (word_op),
        .immed          (immed),
        .jump_if        (jump_if),
        .jump_absolute  (jump_absolute),
        .alu_data_out   (alu_data_out),
        .jump_pc        (jump_pc),
        .jump_taken     (jump_taken),
        .execute_done   (execute_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run-length limit
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // Check helpers
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        protocol_errors++;
    endtask

    // ------------------------------------------------------------------
    // Random decoder output
    // ------------------------------------------------------------------
    function automatic alu_op_t random_alu_op(int unsigned sel);
        return alu_op_t'(4'(sel % 14));
    endfunction

    // Only these go with word mode
    function automatic alu_op_t word_mode_op(int unsigned sel);
        case (sel % 5)
            0:       return ALU_ADD;
            1:       return ALU_SUB;
            2:       return ALU_SLL;
            3:       return ALU_SRL;
            default: return ALU_SRA;
        endcase
    endfunction

    // Compare picked for BEQ, BNE, BLT, BGE, BLTU, BGEU
    function automatic alu_op_t compare_op(int unsigned sel);
        case (sel % 6)
            0:       return ALU_SEQ;
            1:       return ALU_SNE;
            2:       return ALU_SLT;
            3:       return ALU_SGE;
            4:       return ALU_SLTU;
            default: return ALU_SGEU;
        endcase
    endfunction

    task automatic pick_instruction(input int unsigned kind);
        logic [31:0] r;
        r             = $urandom;
        pc            = {$urandom, $urandom} & ~64'h3;
        reg_a         = {$urandom, $urandom};
        reg_b         = {$urandom, $urandom};
        // 12-bit immediate, sign-extended by the decoder
        immed         = {{52{r[11]}}, r[11:0]};
        alu_op        = ALU_ADD;
        word_op       = 1'b0;
        jump_if       = JUMP_NEVER;
        jump_absolute = 1'b0;
        case (kind)
            0: begin
                op_code   = OP_OP;
                alu_op    = random_alu_op($urandom);
                kind_name = "op";
            end
            1: begin
                op_code   = OP_OP_32;
                alu_op    = word_mode_op($urandom);
                word_op   = 1'b1;
                kind_name = "op_32";
            end
            2: begin
                op_code   = OP_OP_IMM;
                alu_op    = random_alu_op($urandom);
                kind_name = "op_imm";
            end
            3: begin
                op_code   = OP_IMM_32;
                alu_op    = word_mode_op($urandom);
                word_op   = 1'b1;
                kind_name = "imm_32";
            end
            4: begin
                op_code   = OP_LUI;
                immed     = {{32{r[31]}}, r[31:12], 12'h000};
                kind_name = "lui";
            end
            5: begin
                op_code   = OP_AUIPC;
                kind_name = "auipc";
            end
            6: begin
                op_code   = OP_JAL;
                jump_if   = JUMP_ALWAYS;
                kind_name = "jal";
            end
            7: begin
                op_code       = OP_JALR;
                jump_if       = JUMP_ALWAYS;
                jump_absolute = 1'b1;
                kind_name     = "jalr";
            end
            8: begin
                op_code   = OP_BRANCH;
                alu_op    = compare_op($urandom);
                jump_if   = JUMP_ON_ALU;
                kind_name = "branch";
                // Equal operands now and then
                if (r[20]) begin
                    reg_b = reg_a;
                end
            end
            9: begin
                op_code   = (r[21]) ? OP_LOAD : ((r[22]) ? OP_STORE : OP_SYSTEM);
                kind_name = "load_store_system";
            end
            default: begin
                // Decoder fields that the bubble must override
                op_code   = OP_OP;
                alu_op    = random_alu_op($urandom);
                jump_if   = JUMP_ALWAYS;
                kind_name = "bubble";
            end
        endcase
        instruction = (kind > 9) ? '0 : {r[31:7], op_code};
    endtask

    // ------------------------------------------------------------------
    // One instruction from enable to done
    // ------------------------------------------------------------------
    task automatic run_instruction(input int idx, input bit with_flush);
        logic [63:0] exp_res;
        logic [63:0] exp_pc;
        logic        exp_taken;
        logic        zero_word;
        int          cycles;
        string       name;
        pick_instruction($urandom % 11);
        zero_word = (instruction == '0);
        exp_res   = stage_result(op_code, alu_op, word_op, pc, reg_a, reg_b, immed, zero_word);
        exp_taken = jump_decision(jump_if, exp_res, zero_word);
        exp_pc    = jump_target(exp_taken, jump_absolute, pc, reg_a, immed);
        name      = $sformatf("test %0d %s", idx, kind_name);
        execute_enable = 1'b1;
        @(negedge clk);
        // Captured already, so the inputs may change
        execute_enable = 1'b0;
        pc      = {$urandom, $urandom};
        reg_a   = {$urandom, $urandom};
        reg_b   = {$urandom, $urandom};
        immed   = {$urandom, $urandom};
        jump_if = JUMP_NEVER;
        if (with_flush) begin
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            for (int k = 0; k < 4; k++) begin
                if (execute_done) begin
                    report_problem($sformatf("%s: execute_done rose after a flush", name));
                end
                @(negedge clk);
            end
        end else begin
            cycles = 1;
            while (!execute_done && cycles < DONE_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (!execute_done) begin
                report_problem($sformatf("%s: execute_done never rose", name));
            end else begin
                check_value({name, " latency"}, 64'd2, 64'(cycles));
                check_value({name, " result"}, exp_res, alu_data_out);
                check_value({name, " jump_taken"}, 64'(exp_taken), 64'(jump_taken));
                check_value({name, " jump_pc"}, exp_pc, jump_pc);
                @(negedge clk);
                if (execute_done) begin
                    report_problem($sformatf("%s: execute_done longer than one cycle", name));
                end
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        value_errors    = 0;
        protocol_errors = 0;
        reset           = 1'b1;
        execute_enable  = 1'b0;
        flush           = 1'b0;
        instruction     = '0;
        pc              = '0;
        reg_a           = '0;
        reg_b           = '0;
        op_code         = OP_OP;
        alu_op          = ALU_ADD;
        word_op         = 1'b0;
        immed           = '0;
        jump_if         = JUMP_NEVER;
        jump_absolute   = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // Outputs right after reset
        check_value("reset result", 64'h0, alu_data_out);
        check_value("reset jump_pc", 64'h0, jump_pc);
        check_value("reset jump_taken", 64'h0, 64'(jump_taken));
        check_value("reset execute_done", 64'h0, 64'(execute_done));
        for (int i = 0; i < NUM_TESTS; i++) begin
            // Every eighth instruction is flushed, the next one runs normally
            run_instruction(i, (i % 8) == 7);
        end
        $display("Tests: %0d, value errors: %0d, protocol errors: %0d",
                 NUM_TESTS, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+sim
rtl/rv_isa_pkg.sv
rtl/ex_stage_pkg.sv
rtl/ex_operand_if.sv
rtl/ex_operand_select.sv
rtl/ex_alu.sv
rtl/ex_branch_resolve.sv
rtl/ex_sequencer.sv
rtl/execute_stage.sv
sim/execute_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module execute_stage_tb -f flist.f -o execute_stage_sim &&
    ./obj_dir/execute_stage_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log &&
    echo "Run passed" ||
    { echo "Run did not pass"; exit 1; }
